// ==== common/muldiv_pkg.sv ====
package muldiv_pkg;

  localparam int xlen = 32;

  // RISC-V M extension funct3 encodings.
  localparam logic [2:0] f3_mul    = 3'd0;
  localparam logic [2:0] f3_mulh   = 3'd1;
  localparam logic [2:0] f3_mulhsu = 3'd2;
  localparam logic [2:0] f3_mulhu  = 3'd3;
  localparam logic [2:0] f3_div    = 3'd4;
  localparam logic [2:0] f3_divu   = 3'd5;
  localparam logic [2:0] f3_rem    = 3'd6;
  localparam logic [2:0] f3_remu   = 3'd7;

  localparam int addr_width = 5;

  // APB register map, byte offsets.
  localparam logic [addr_width-1:0] addr_op1    = 5'h00;
  localparam logic [addr_width-1:0] addr_op2    = 5'h04;
  localparam logic [addr_width-1:0] addr_ctrl   = 5'h08;
  localparam logic [addr_width-1:0] addr_status = 5'h0C;
  localparam logic [addr_width-1:0] addr_result = 5'h10;

  // Status register bit positions.
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

  // One bit per operation; exactly one is set for a valid request.
  typedef struct packed {
    logic remu;
    logic rem;
    logic divu;
    logic div;
    logic mulhu;
    logic mulhsu;
    logic mulh;
    logic mul;
  } muldiv_op_t;

endpackage

// ==== muldiv/muldiv_lzc.sv ====
`timescale 1ns/1ps

module muldiv_lzc import muldiv_pkg::*; (
  input  logic [xlen-1:0] value,
  output logic [5:0]      count
);

  // Scan upward so the highest set bit decides the count.
  always_comb begin
    count = 6'd32; // All zero.
    for (int i = 0; i < xlen; i++) begin
      if (value[i]) begin
        count = 6'(xlen - 1 - i);
      end
    end
  end

endmodule

// ==== muldiv/muldiv.sv ====
`timescale 1ns/1ps

module muldiv import muldiv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            enable,
  input  logic [xlen-1:0] rdata1,
  input  logic [xlen-1:0] rdata2,
  input  muldiv_op_t      op,
  output logic [xlen-1:0] result,
  output logic            ready
);

  typedef struct packed {
    logic [5:0]      counter;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    muldiv_op_t      op;
    logic            mul_op;
    logic            div_op;
    logic            negative;
    logic            op1_neg;
    logic            div_zero;
    logic            overflow;
    logic [64:0]     acc;
  } muldiv_reg_t;

  muldiv_reg_t r;
  muldiv_reg_t r_next;

  logic            op1_signed;
  logic            op2_signed;
  logic            mul_in;
  logic            div_in;
  logic            div_zero_in;
  logic            overflow_in;
  logic [xlen-1:0] op1_abs;
  logic [xlen-1:0] op2_abs;
  logic [5:0]      lz_count;
  logic [5:0]      start_count;
  logic [5:0]      bit_sel;
  logic [xlen-1:0] dividend;
  logic [64:0]     acc_shift;
  logic [64:0]     acc_sub;
  logic [64:0]     acc_fix;

  assign op1_signed = op.mul | op.mulh | op.mulhsu | op.div | op.rem;
  assign op2_signed = op.mul | op.mulh | op.div | op.rem;
  assign mul_in     = op.mul | op.mulh | op.mulhsu | op.mulhu;
  assign div_in     = op.div | op.divu | op.rem | op.remu;

  assign op1_abs = (op1_signed && rdata1[xlen-1]) ? -rdata1 : rdata1;
  assign op2_abs = (op2_signed && rdata2[xlen-1]) ? -rdata2 : rdata2;

  assign div_zero_in = div_in && (rdata2 == '0);
  assign overflow_in = (op.div | op.rem) && (rdata1 == 32'h8000_0000) && (rdata2 == '1);

  muldiv_lzc u_muldiv_lzc (
    .value (op1_abs),
    .count (lz_count)
  );

  // Corner cases skip the loop entirely.
  assign start_count = (div_zero_in || overflow_in) ? 6'd32 : lz_count;

  // Multiplier bit consumed in the current iteration.
  assign bit_sel = 6'd32 - r.counter;

  assign dividend = r.op1_neg ? -r.op1 : r.op1; // Original signed dividend.

  assign acc_shift = {r.acc[63:0], 1'b0};
  assign acc_sub   = {acc_shift[64:32] - {1'b0, r.op2}, acc_shift[31:0]};

  always_comb begin
    r_next  = r;
    result  = '0;
    ready   = 1'b0;
    acc_fix = r.acc;
    case (r.counter)
      6'd0: begin
        r_next.op1      = op1_abs;
        r_next.op2      = op2_abs;
        r_next.op       = op;
        r_next.mul_op   = mul_in;
        r_next.div_op   = div_in;
        r_next.op1_neg  = op1_signed & rdata1[xlen-1];
        r_next.negative = (op1_signed & rdata1[xlen-1]) ^ (op2_signed & rdata2[xlen-1]);
        r_next.div_zero = div_zero_in;
        r_next.overflow = overflow_in;
        if (mul_in) begin
          r_next.acc = '0;
        end else begin
          r_next.acc = {33'b0, op1_abs} << lz_count; // Dividend aligned to its top bit.
        end
        if (enable) begin
          r_next.counter = start_count + 6'd1;
        end else begin
          r_next.counter = 6'd0;
        end
      end
      6'd33: begin
        if (r.negative) begin
          if (r.mul_op) begin
            acc_fix = -r.acc;
          end else begin
            acc_fix[31:0] = -r.acc[31:0]; // Quotient sign.
          end
        end
        if (r.op1_neg && r.div_op) begin
          acc_fix[63:32] = -acc_fix[63:32]; // Remainder follows the dividend.
        end
        if (r.op.mul) begin
          result = acc_fix[31:0];
        end else if (r.op.mulh || r.op.mulhsu || r.op.mulhu) begin
          result = acc_fix[63:32];
        end else if (r.op.div || r.op.divu) begin
          if (r.div_zero) begin
            result = '1;
          end else if (r.overflow) begin
            result = 32'h8000_0000;
          end else begin
            result = acc_fix[31:0];
          end
        end else if (r.op.rem || r.op.remu) begin
          if (r.div_zero) begin
            result = dividend;
          end else if (r.overflow) begin
            result = '0;
          end else begin
            result = acc_fix[63:32];
          end
        end
        ready          = 1'b1;
        r_next.counter = 6'd0;
      end
      default: begin
        if (r.mul_op) begin
          if (r.op1[bit_sel[4:0]]) begin
            r_next.acc = acc_shift + {33'b0, r.op2};
          end else begin
            r_next.acc = acc_shift;
          end
        end else if (r.div_op) begin
          if (acc_sub[64]) begin
            r_next.acc = acc_shift; // Restore.
          end else begin
            r_next.acc = {acc_sub[64:1], 1'b1};
          end
        end
        r_next.counter = r.counter + 6'd1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r.counter <= '0;
    end else begin
      r <= r_next;
    end
  end

  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
    ready |=> !ready);

  a_op_onehot: assert property (@(posedge clk) disable iff (!rst)
    enable |-> $onehot(op));

endmodule

// ==== hw/muldiv_apb_regs.sv ====
`timescale 1ns/1ps

module muldiv_apb_regs import muldiv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [addr_width-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [xlen-1:0]       pwdata,
  output logic [xlen-1:0]       prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic [xlen-1:0]       result,
  input  logic                  ready,
  output logic [xlen-1:0]       rdata1,
  output logic [xlen-1:0]       rdata2,
  output muldiv_op_t            op,
  output logic                  enable
);

  logic [xlen-1:0] op1_q;
  logic [xlen-1:0] op2_q;
  logic [xlen-1:0] result_q;
  logic [2:0]      funct3_q;
  logic            busy;
  logic            done;

  logic access;
  logic wr_access;
  logic rd_access;
  logic mapped;
  logic operand_sel;
  logic write_refused;
  logic start;

  assign access    = psel & penable;
  assign wr_access = access & pwrite;
  assign rd_access = access & ~pwrite;

  assign mapped = (paddr == addr_op1) || (paddr == addr_op2) || (paddr == addr_ctrl) ||
                  (paddr == addr_status) || (paddr == addr_result);

  assign operand_sel   = (paddr == addr_op1) || (paddr == addr_op2) || (paddr == addr_ctrl);
  assign write_refused = wr_access & busy & operand_sel;
  assign start         = wr_access & ~busy & (paddr == addr_ctrl);

  assign pready  = 1'b1; // No wait states.
  assign pslverr = access & (~mapped | write_refused);

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        addr_op1:    prdata = op1_q;
        addr_op2:    prdata = op2_q;
        addr_ctrl:   prdata = {29'b0, funct3_q};
        addr_status: begin
          prdata[status_busy_bit] = busy;
          prdata[status_done_bit] = done;
        end
        addr_result: prdata = result_q;
        default:     prdata = '0;
      endcase
    end
  end

  // Operands only change while idle.
  always_ff @(posedge clk) begin
    if (wr_access && !busy) begin
      if (paddr == addr_op1) begin
        op1_q <= pwdata;
      end
      if (paddr == addr_op2) begin
        op2_q <= pwdata;
      end
    end
    if (ready) begin
      result_q <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      funct3_q <= f3_mul;
      enable   <= 1'b0;
      busy     <= 1'b0;
      done     <= 1'b0;
    end else begin
      enable <= start;
      if (start) begin
        funct3_q <= pwdata[2:0];
        busy     <= 1'b1;
        done     <= 1'b0;
      end else if (ready) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else if (rd_access && paddr == addr_result) begin
        done <= 1'b0; // Result consumed.
      end
    end
  end

  assign rdata1 = op1_q;
  assign rdata2 = op2_q;

  always_comb begin
    op = '0;
    case (funct3_q)
      f3_mul:    op.mul    = 1'b1;
      f3_mulh:   op.mulh   = 1'b1;
      f3_mulhsu: op.mulhsu = 1'b1;
      f3_mulhu:  op.mulhu  = 1'b1;
      f3_div:    op.div    = 1'b1;
      f3_divu:   op.divu   = 1'b1;
      f3_rem:    op.rem    = 1'b1;
      f3_remu:   op.remu   = 1'b1;
      default:   op        = '0;
    endcase
  end

  // Start pulse is only issued from idle.
  a_enable_idle: assert property (@(posedge clk) disable iff (!rst)
    enable |-> !$past(busy));

  a_ready_busy: assert property (@(posedge clk) disable iff (!rst)
    ready |-> busy);

endmodule

// ==== hw/muldiv_apb_top.sv ====
`timescale 1ns/1ps

module muldiv_apb_top import muldiv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [addr_width-1:0] paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [xlen-1:0]       pwdata,
  output logic [xlen-1:0]       prdata,
  output logic                  pready,
  output logic                  pslverr
);

  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [xlen-1:0] result;
  muldiv_op_t      op;
  logic            enable;
  logic            ready;

  muldiv_apb_regs u_muldiv_apb_regs (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .result  (result),
    .ready   (ready),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .op      (op),
    .enable  (enable)
  );

  muldiv u_muldiv (
    .clk    (clk),
    .rst    (rst),
    .enable (enable),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .op     (op),
    .result (result),
    .ready  (ready)
  );

endmodule

// ==== bench/tb_muldiv_apb_top.sv ====
`timescale 1ns/1ps

module tb_muldiv_apb_top import muldiv_pkg::*;;

  localparam int max_words    = 256;
  localparam int random_count = 20;
  localparam int extra_count  = 4; // Reset, unmapped and busy sequences.

  logic                  clk = 1'b0;
  logic                  rst;
  logic [addr_width-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [xlen-1:0]       pwdata;
  logic [xlen-1:0]       prdata;
  logic                  pready;
  logic                  pslverr;

  logic [31:0] test_mem [0:max_words-1];
  int          num_tests;
  int          cycle_count = 0;
  int          cycle_limit = 200;
  integer      seed;

  muldiv_apb_top u_muldiv_apb_top (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run went past its limit of %0d clock cycles.", cycle_limit);
      $display("sim failed");
      $fatal(1, "Cycle limit reached.");
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("sim failed");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the edge that ends the access.
  task automatic apb_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
                           output logic err);
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    err = pslverr;
    check("pready", 32'(pready), 32'd1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [addr_width-1:0] addr, output logic [31:0] data,
                          output logic err);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    data = prdata; // Sampled mid access cycle.
    err  = pslverr;
    check("pready", 32'(pready), 32'd1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input logic [addr_width-1:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check($sformatf("pslverr (write 0x%02h)", addr), 32'(err), 32'd0);
  endtask

  task automatic read_reg(input logic [addr_width-1:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    check($sformatf("pslverr (read 0x%02h)", addr), 32'(err), 32'd0);
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    status = 32'h1;
    while (status[status_busy_bit] == 1'b1) begin
      read_reg(addr_status, status);
    end
  endtask

  task automatic run_op(input int idx, input logic [2:0] func, input logic [31:0] a,
                        input logic [31:0] b, input logic [31:0] expected);
    logic [31:0] value;
    write_reg(addr_op1, a);
    write_reg(addr_op2, b);
    write_reg(addr_ctrl, {29'b0, func});
    wait_idle();
    read_reg(addr_status, value);
    check($sformatf("prdata (status, test %0d)", idx), value, 32'h2);
    read_reg(addr_result, value);
    check($sformatf("prdata (result, test %0d, funct3 %0d)", idx, func), value, expected);
  endtask

  initial begin
    int          k;
    logic [7:0]  base;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [63:0] prod;
    logic        err;
    rst     = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    seed    = 32'hb0b6_9b33;

    for (k = 0; k < max_words; k++) begin
      test_mem[8'(k)] = 32'hdead_0000 ^ 32'(k); // No valid funct3 in the fill.
    end
    $readmemh("bench/muldiv_tests.hex", test_mem);
    num_tests = 0;
    while (num_tests < max_words / 4 && test_mem[8'(4 * num_tests)] < 32'd8) begin
      num_tests = num_tests + 1;
    end
    if (num_tests == 0) begin
      $display("No test vectors could be read from bench/muldiv_tests.hex.");
      $display("sim failed");
      $fatal(1, "Missing test data.");
    end
    cycle_limit = (num_tests + random_count + extra_count) * 60 + 200;

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b1;

    read_reg(addr_status, value);
    check("prdata (status after reset)", value, 32'h0);
    apb_read(5'h14, value, err);
    check("prdata (unmapped 0x14)", value, 32'h0);
    check("pslverr (unmapped 0x14)", 32'(err), 32'd1);
    apb_read(5'h1C, value, err);
    check("prdata (unmapped 0x1C)", value, 32'h0);
    check("pslverr (unmapped 0x1C)", 32'(err), 32'd1);

    for (k = 0; k < num_tests; k++) begin
      base = 8'(4 * k);
      run_op(k, test_mem[base][2:0], test_mem[base + 8'd1], test_mem[base + 8'd2],
             test_mem[base + 8'd3]);
    end

    for (k = 0; k < random_count; k++) begin
      a    = $random(seed);
      b    = $random(seed);
      prod = {32'b0, a} * {32'b0, b};
      if (k % 2 == 0) begin
        run_op(num_tests + k, f3_mul, a, b, prod[31:0]);
      end else begin
        run_op(num_tests + k, f3_mulhu, a, b, prod[63:32]);
      end
    end

    // Long divu, then writes that must be refused while it runs.
    write_reg(addr_op1, 32'hffff_ffff);
    write_reg(addr_op2, 32'h0000_0010);
    write_reg(addr_ctrl, {29'b0, f3_divu});
    read_reg(addr_status, value);
    check("prdata (status while busy)", value, 32'h1);
    apb_write(addr_op1, 32'h0000_0001, err);
    check("pslverr (op1 write while busy)", 32'(err), 32'd1);
    apb_write(addr_op2, 32'h0000_0003, err);
    check("pslverr (op2 write while busy)", 32'(err), 32'd1);
    apb_write(addr_ctrl, {29'b0, f3_mul}, err);
    check("pslverr (ctrl write while busy)", 32'(err), 32'd1);
    wait_idle();
    read_reg(addr_status, value);
    check("prdata (status when done)", value, 32'h2);
    read_reg(addr_result, value);
    check("prdata (result after refused writes)", value, 32'h0fff_ffff);
    read_reg(addr_status, value);
    check("prdata (status after result read)", value, 32'h0);
    read_reg(addr_op1, value);
    check("prdata (op1 after refused write)", value, 32'hffff_ffff);
    read_reg(addr_ctrl, value);
    check("prdata (ctrl after refused write)", value, {29'b0, f3_divu});

    // Second run on the operand registers as they stand.
    write_reg(addr_ctrl, {29'b0, f3_divu});
    wait_idle();
    read_reg(addr_result, value);
    check("prdata (result with kept operands)", value, 32'h0fff_ffff);

    $display("sim passed");
    $finish;
  end

endmodule

// ==== bench/muldiv_tests.hex ====
// Columns: funct3, operand one, operand two, expected result (all hex).
// funct3: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 div, 5 divu, 6 rem, 7 remu.
0 00000003 00000007 00000015
0 FFFFFFFF FFFFFFFF 00000001
0 12345678 00000010 23456780
0 FFFFFFFE 00000005 FFFFFFF6
0 00000000 DEADBEEF 00000000
0 80000000 00000002 00000000
1 FFFFFFFF FFFFFFFF 00000000
1 80000000 80000000 40000000
1 FFFFFFFE 00000005 FFFFFFFF
1 7FFFFFFF 7FFFFFFF 3FFFFFFF
1 00010000 00010000 00000001
2 FFFFFFFF FFFFFFFF FFFFFFFF
2 00000002 80000000 00000001
2 80000000 FFFFFFFF 80000000
2 00000003 00000005 00000000
3 FFFFFFFF FFFFFFFF FFFFFFFE
3 80000000 00000004 00000002
3 00000001 FFFFFFFF 00000000
3 00010000 ABCD0000 0000ABCD
4 00000014 00000006 00000003
4 FFFFFFEC 00000006 FFFFFFFD
4 00000014 FFFFFFFA FFFFFFFD
4 FFFFFFEC FFFFFFFA 00000003
4 80000000 FFFFFFFF 80000000
4 00000007 00000000 FFFFFFFF
4 80000000 00000002 C0000000
5 FFFFFFFF 00000010 0FFFFFFF
5 FFFFFFEC 00000006 2AAAAAA7
5 00000009 00000000 FFFFFFFF
5 00000005 00000007 00000000
6 00000014 00000006 00000002
6 FFFFFFEC 00000006 FFFFFFFE
6 00000014 FFFFFFFA 00000002
6 FFFFFFEC FFFFFFFA FFFFFFFE
6 80000000 FFFFFFFF 00000000
6 FFFFFFF9 00000000 FFFFFFF9
7 FFFFFFEC 00000006 00000002
7 00000064 0000000B 00000001
7 12345678 00000000 12345678
7 80000000 FFFFFFFF 80000000

// ==== filelist.f ====
common/muldiv_pkg.sv
muldiv/muldiv_lzc.sv
muldiv/muldiv.sv
hw/muldiv_apb_regs.sv
hw/muldiv_apb_top.sv
bench/tb_muldiv_apb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_muldiv_apb_top \
  -f filelist.f -o tb_muldiv_apb_top

# The simulator exits non-zero on $fatal; the log decides the outcome.
./obj_dir/tb_muldiv_apb_top > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "Simulation ended without a result line."
  exit 1
fi
exit 0
